// File: logic/snd_settings.svh
// Build-time constants for the sound output block
// SND_CEN_DIV must be at least 2, and SND_DW must exceed SND_SW by at least 2
`ifndef SND_SETTINGS_SVH
`define SND_SETTINGS_SVH

`default_nettype none

// clk_dac cycles per DAC update tick
`define SND_CEN_DIV 4

// Update ticks spent at mid-scale before play
`define SND_WARM_TICKS 16

// Game sample width
`define SND_SW 16

// Modulator word width, one guard bit above the sample plus low padding
`define SND_DW 20

`default_nettype wire

`endif

// File: logic/snd_pkg.sv
// Shared types for the sound output block
// Widths come from the settings header
`include "snd_settings.svh"
`default_nettype none

package snd_pkg;

    // One game sample, decoded either as two's complement PCM
    // or as offset binary where 0x8000 is silence
    typedef union packed {
        logic signed [`SND_SW-1:0] pcm;
        logic        [`SND_SW-1:0] ofs;
    } snd_word_u;

    // Left in the upper half, right in the lower half
    typedef struct packed {
        snd_word_u left;
        snd_word_u right;
    } snd_frame_t;

    // Output control states
    typedef enum logic [1:0] {
        MUTE = 2'd0,
        WARM = 2'd1,
        PLAY = 2'd2
    } snd_state_e;

endpackage

`default_nettype wire

// File: logic/snd_cen_timer.sv
// DAC update-rate divider and warm-up tick counter
// warm_clr_i is expected only in a tick cycle, and that tick counts as warm-up tick one
`timescale 1ns/100ps
`include "snd_settings.svh"
`default_nettype none

module snd_cen_timer (
    input  wire logic clk_dac,
    input  wire logic rst,
    input  wire logic warm_clr_i,
    output logic      cen_o,
    output logic      warm_done_o
);

localparam int DIV_W  = $clog2(`SND_CEN_DIV);
localparam int TICK_W = $clog2(`SND_WARM_TICKS + 1);

logic [DIV_W-1:0]  div_cnt;
logic [TICK_W-1:0] tick_cnt;

// One tick every SND_CEN_DIV cycles, the first on the last count
assign cen_o = div_cnt == DIV_W'(`SND_CEN_DIV - 1);

always_ff @(posedge clk_dac, posedge rst) begin
    if (rst) begin
        div_cnt <= '0;
    end else if (cen_o) begin
        div_cnt <= '0;
    end else begin
        div_cnt <= div_cnt + 1'b1;
    end
end

// Saturates at the warm-up length until the next clear
assign warm_done_o = tick_cnt == TICK_W'(`SND_WARM_TICKS);

always_ff @(posedge clk_dac, posedge rst) begin
    if (rst) begin
        tick_cnt <= '0;
    end else if (warm_clr_i) begin
        tick_cnt <= TICK_W'(1);
    end else if (cen_o && !warm_done_o) begin
        tick_cnt <= tick_cnt + 1'b1;
    end
end

endmodule

`default_nettype wire

// File: logic/snd_ctrl_fsm.sv
// Mute, warm-up and play control for the sound path
// State moves only on update ticks; en_i is sampled as a level on each tick
`timescale 1ns/100ps
`default_nettype none

module snd_ctrl_fsm (
    input  wire logic clk_dac,
    input  wire logic rst,
    input  wire logic cen_i,
    input  wire logic en_i,
    input  wire logic warm_done_i,
    output logic      warm_clr_o,
    output logic      sel_mid_o,
    output logic      dac_run_o,
    output logic      playing_o
);

snd_pkg::snd_state_e state;
snd_pkg::snd_state_e state_nx;

always_comb begin
    state_nx = state;
    if (!en_i) begin
        // Disable wins from any state
        state_nx = snd_pkg::MUTE;
    end else begin
        case (state)
            snd_pkg::MUTE: begin
                state_nx = snd_pkg::WARM;
            end
            snd_pkg::WARM: begin
                if (warm_done_i) begin
                    state_nx = snd_pkg::PLAY;
                end
            end
            default: begin
                state_nx = state;
            end
        endcase
    end
end

always_ff @(posedge clk_dac, posedge rst) begin
    if (rst) begin
        state <= snd_pkg::MUTE;
    end else if (cen_i) begin
        state <= state_nx;
    end
end

// Restart the warm-up count on the tick that leaves MUTE
assign warm_clr_o = cen_i && en_i && (state == snd_pkg::MUTE);

// Mid-scale is fed in MUTE and WARM so play starts from a settled level
assign sel_mid_o = state != snd_pkg::PLAY;

// Modulators are held cleared only while muted
assign dac_run_o = state != snd_pkg::MUTE;

assign playing_o = state == snd_pkg::PLAY;

endmodule

`default_nettype wire

// File: logic/snd_sample_fmt.sv
// Sample capture and conversion to padded modulator words
// Samples must already be synchronous to clk_dac; changes between ticks are not seen
`timescale 1ns/100ps
`include "snd_settings.svh"
`default_nettype none

module snd_sample_fmt (
    input  wire logic                clk_dac,
    input  wire logic                rst,
    input  wire logic                cen_i,
    input  wire snd_pkg::snd_frame_t frame_i,
    input  wire logic                signed_i,
    input  wire logic                stereo_i,
    input  wire logic                sel_mid_i,
    output logic [`SND_DW-1:0]       word_l_o,
    output logic [`SND_DW-1:0]       word_r_o
);

localparam int PAD_W = `SND_DW - `SND_SW - 1;
localparam logic [`SND_DW-1:0] MID_WORD = {1'b0, 1'b1, {(`SND_SW-1){1'b0}}, {PAD_W{1'b0}}};

// Guard bit, offset-binary sample, low zero padding
function automatic logic [`SND_DW-1:0] pad_word(input snd_pkg::snd_word_u w,
                                                input logic is_signed);
    logic [`SND_SW-1:0] ofs;
    if (is_signed) begin
        // Flipping the sign bit maps PCM onto offset binary
        ofs = {~w.pcm[`SND_SW-1], w.pcm[`SND_SW-2:0]};
    end else begin
        ofs = w.ofs;
    end
    return {1'b0, ofs, {PAD_W{1'b0}}};
endfunction

snd_pkg::snd_word_u src_r;

// Mono games play the left channel on both pins
assign src_r = stereo_i ? frame_i.right : frame_i.left;

always_ff @(posedge clk_dac, posedge rst) begin
    if (rst) begin
        word_l_o <= MID_WORD;
        word_r_o <= MID_WORD;
    end else if (cen_i) begin
        if (sel_mid_i) begin
            word_l_o <= MID_WORD;
            word_r_o <= MID_WORD;
        end else begin
            word_l_o <= pad_word(frame_i.left, signed_i);
            word_r_o <= pad_word(src_r, signed_i);
        end
    end
end

endmodule

`default_nettype wire

// File: logic/snd_sd_dac.sv
// First-order delta-sigma modulator for one channel
// The pin is the carry out of the accumulator, registered once per tick
`timescale 1ns/100ps
`include "snd_settings.svh"
`default_nettype none

module snd_sd_dac (
    input  wire logic               clk_dac,
    input  wire logic               rst,
    input  wire logic               cen_i,
    input  wire logic               run_i,
    input  wire logic [`SND_DW-1:0] word_i,
    output logic                    dac_o
);

logic [`SND_DW-1:0] acc;
logic [`SND_DW:0]   sum;

// Residue plus new word; the top bit is the output pulse
assign sum = {1'b0, acc} + {1'b0, word_i};

always_ff @(posedge clk_dac, posedge rst) begin
    if (rst) begin
        acc   <= '0;
        dac_o <= 1'b0;
    end else if (!run_i) begin
        // Held every cycle, not just on ticks, so mute is immediate
        acc   <= '0;
        dac_o <= 1'b0;
    end else if (cen_i) begin
        acc   <= sum[`SND_DW-1:0];
        dac_o <= sum[`SND_DW];
    end
end

endmodule

`default_nettype wire

// File: logic/snd_dac_top.sv
// Sound output block: two 1-bit delta-sigma DAC pins from 16-bit game samples
// All inputs are assumed synchronous to clk_dac
`timescale 1ns/100ps
`include "snd_settings.svh"
`default_nettype none

module snd_dac_top (
    input  wire logic              clk_dac,
    input  wire logic              rst,
    input  wire logic              en_i,
    input  wire logic              signed_i,
    input  wire logic              stereo_i,
    input  wire logic [`SND_SW-1:0] snd_left_i,
    input  wire logic [`SND_SW-1:0] snd_right_i,
    output logic                   dac_left_o,
    output logic                   dac_right_o,
    output logic                   playing_o
);

logic cen;
logic warm_done;
logic warm_clr;
logic sel_mid;
logic dac_run;

logic [`SND_DW-1:0] word_l;
logic [`SND_DW-1:0] word_r;

snd_pkg::snd_frame_t frame;

// Left channel in the upper half
assign frame = {snd_left_i, snd_right_i};

snd_cen_timer i_timer (
    .clk_dac     ( clk_dac   ),
    .rst         ( rst       ),
    .warm_clr_i  ( warm_clr  ),
    .cen_o       ( cen       ),
    .warm_done_o ( warm_done )
);

snd_ctrl_fsm i_fsm (
    .clk_dac     ( clk_dac   ),
    .rst         ( rst       ),
    .cen_i       ( cen       ),
    .en_i        ( en_i      ),
    .warm_done_i ( warm_done ),
    .warm_clr_o  ( warm_clr  ),
    .sel_mid_o   ( sel_mid   ),
    .dac_run_o   ( dac_run   ),
    .playing_o   ( playing_o )
);

snd_sample_fmt i_fmt (
    .clk_dac   ( clk_dac  ),
    .rst       ( rst      ),
    .cen_i     ( cen      ),
    .frame_i   ( frame    ),
    .signed_i  ( signed_i ),
    .stereo_i  ( stereo_i ),
    .sel_mid_i ( sel_mid  ),
    .word_l_o  ( word_l   ),
    .word_r_o  ( word_r   )
);

// One modulator per pin
snd_sd_dac i_dac_l (
    .clk_dac ( clk_dac    ),
    .rst     ( rst        ),
    .cen_i   ( cen        ),
    .run_i   ( dac_run    ),
    .word_i  ( word_l     ),
    .dac_o   ( dac_left_o )
);

snd_sd_dac i_dac_r (
    .clk_dac ( clk_dac     ),
    .rst     ( rst         ),
    .cen_i   ( cen         ),
    .run_i   ( dac_run     ),
    .word_i  ( word_r      ),
    .dac_o   ( dac_right_o )
);

endmodule

`default_nettype wire

// File: tests/snd_dac_props.sv
// Concurrent checks on the sound output block, attached to snd_dac_top with bind
// The cen spacing check assumes the default divider of 4 clk_dac cycles
`timescale 1ns/100ps
`default_nettype none

module snd_dac_props (
    input wire logic clk_dac,
    input wire logic rst,
    input wire logic cen_i,
    input wire logic dac_run_i,
    input wire logic en_i,
    input wire logic stereo_i,
    input wire logic dac_left_i,
    input wire logic dac_right_i,
    input wire logic playing_i
);

int   fail_cnt = 0;
logic tick_en;

// en_i as seen at the most recent tick
always_ff @(posedge clk_dac, posedge rst) begin
    if (rst) begin
        tick_en <= 1'b0;
    end else if (cen_i) begin
        tick_en <= en_i;
    end
end

a_cen_rate: assert property (@(posedge clk_dac) disable iff (rst)
    cen_i |=> !cen_i ##1 !cen_i ##1 !cen_i ##1 cen_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("cen is not one cycle in four");
    end

// Modulators clear one cycle after dac_run drops
a_mute_pins: assert property (@(posedge clk_dac) disable iff (rst)
    !dac_run_i |=> (!dac_left_i && !dac_right_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("DAC pins active while muted");
    end

a_mono_copy: assert property (@(posedge clk_dac) disable iff (rst)
    !stereo_i |-> (dac_right_i == dac_left_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("right pin differs from left pin in mono");
    end

a_play_en: assert property (@(posedge clk_dac) disable iff (rst)
    playing_i |-> tick_en)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("playing without en_i at the last tick");
    end

endmodule

bind snd_dac_top snd_dac_props i_props (
    .clk_dac     ( clk_dac     ),
    .rst         ( rst         ),
    .cen_i       ( cen         ),
    .dac_run_i   ( dac_run     ),
    .en_i        ( en_i        ),
    .stereo_i    ( stereo_i    ),
    .dac_left_i  ( dac_left_o  ),
    .dac_right_i ( dac_right_o ),
    .playing_i   ( playing_o   )
);

`default_nettype wire

// File: tests/tb_snd_dac.sv
// Testbench for the sound output block with a cycle model of ticks, states and modulators
// Tick positions are counted from reset with the fixed divider
`timescale 1ns/100ps
`include "snd_settings.svh"
`default_nettype none

module tb_snd_dac;

localparam int HALF_NS      = 4;
localparam int DIV          = `SND_CEN_DIV;
localparam int WARM         = `SND_WARM_TICKS;
localparam int SW           = `SND_SW;
localparam int DW           = `SND_DW;
localparam int PAD_W        = DW - SW - 1;
localparam int RST_CYC      = 4;
localparam int IDLE_TICKS   = 10;
localparam int PLAY_TICKS   = 200;
localparam int MUTE_TICKS   = 6;
localparam int MARGIN_TICKS = 50;
// Idle, two warm-ups, two play runs and two mutes
localparam int TOTAL_TICKS  = IDLE_TICKS + 2 * (WARM + 2) + 2 * PLAY_TICKS
                              + 2 * (MUTE_TICKS + 2) + MARGIN_TICKS;
localparam int TIMEOUT_NS   = (RST_CYC + TOTAL_TICKS * DIV) * 2 * HALF_NS;

localparam int ST_MUTE = 0;
localparam int ST_WARM = 1;
localparam int ST_PLAY = 2;

localparam logic [SW-1:0] MID_SAMPLE = 1 << (SW - 1);

logic          clk_dac;
logic          rst;
logic          en_i;
logic          signed_i;
logic          stereo_i;
logic [SW-1:0] snd_left_i;
logic [SW-1:0] snd_right_i;
logic          dac_left_o;
logic          dac_right_o;
logic          playing_o;

integer seed;
string  test_name;

// Model state
int          m_cyc;
int          m_state;
int          m_warm;
logic        m_tick;
logic [DW-1:0] m_word_l;
logic [DW-1:0] m_word_r;
logic [DW-1:0] m_acc_l;
logic [DW-1:0] m_acc_r;
logic [DW:0]   m_sum_l;
logic [DW:0]   m_sum_r;
logic        m_dac_l;
logic        m_dac_r;

snd_dac_top i_dut (
    .clk_dac     ( clk_dac     ),
    .rst         ( rst         ),
    .en_i        ( en_i        ),
    .signed_i    ( signed_i    ),
    .stereo_i    ( stereo_i    ),
    .snd_left_i  ( snd_left_i  ),
    .snd_right_i ( snd_right_i ),
    .dac_left_o  ( dac_left_o  ),
    .dac_right_o ( dac_right_o ),
    .playing_o   ( playing_o   )
);

always #HALF_NS clk_dac = ~clk_dac;

// Offset binary gets a zero guard bit on top and zero padding below
function automatic logic [DW-1:0] ref_word(input logic [SW-1:0] s, input logic is_signed);
    logic [SW-1:0] ob;
    ob = is_signed ? (s ^ MID_SAMPLE) : s;
    return {1'b0, ob, {PAD_W{1'b0}}};
endfunction

// Carry out of residue plus word is the next pin value
function automatic logic [DW:0] ref_step(input logic [DW-1:0] acc, input logic [DW-1:0] word);
    return {1'b0, acc} + {1'b0, word};
endfunction

always @(posedge clk_dac or posedge rst) begin
    if (rst) begin
        m_cyc    = 0;
        m_state  = ST_MUTE;
        m_warm   = 0;
        m_tick   = 1'b0;
        m_word_l = ref_word(MID_SAMPLE, 1'b0);
        m_word_r = ref_word(MID_SAMPLE, 1'b0);
        m_acc_l  = '0;
        m_acc_r  = '0;
        m_dac_l  = 1'b0;
        m_dac_r  = 1'b0;
    end else begin
        m_tick = (m_cyc % DIV) == DIV - 1;
        m_cyc  = m_cyc + 1;
        // Modulators use the word registered at the previous tick
        if (m_state == ST_MUTE) begin
            m_acc_l = '0;
            m_acc_r = '0;
            m_dac_l = 1'b0;
            m_dac_r = 1'b0;
        end else if (m_tick) begin
            m_sum_l = ref_step(m_acc_l, m_word_l);
            m_sum_r = ref_step(m_acc_r, m_word_r);
            m_acc_l = m_sum_l[DW-1:0];
            m_acc_r = m_sum_r[DW-1:0];
            m_dac_l = m_sum_l[DW];
            m_dac_r = m_sum_r[DW];
        end
        if (m_tick) begin
            if (m_state != ST_PLAY) begin
                m_word_l = ref_word(MID_SAMPLE, 1'b0);
                m_word_r = ref_word(MID_SAMPLE, 1'b0);
            end else begin
                m_word_l = ref_word(snd_left_i, signed_i);
                m_word_r = ref_word(stereo_i ? snd_right_i : snd_left_i, signed_i);
            end
            if (!en_i) begin
                m_state = ST_MUTE;
            end else if (m_state == ST_MUTE) begin
                m_state = ST_WARM;
                m_warm  = 1;
            end else if (m_state == ST_WARM) begin
                if (m_warm == WARM) begin
                    m_state = ST_PLAY;
                end else begin
                    m_warm = m_warm + 1;
                end
            end
        end
    end
end

task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("** Error: test %s, %s expected %0h actual %0h",
                 test_name, what, exp, act);
        $display("TB FAILED");
        $fatal(1, "value mismatch at %0t", $time);
    end
endtask

// Outputs are registered, so the falling edge sees settled values
always @(negedge clk_dac) begin
    if (!rst) begin
        check_val("dac_left_o", m_dac_l, dac_left_o);
        check_val("dac_right_o", m_dac_r, dac_right_o);
        check_val("playing_o", m_state == ST_PLAY, playing_o);
        if (i_dut.i_props.fail_cnt != 0) begin
            $display("Error: test %s, a bound assertion failed at %0t", test_name, $time);
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end
    end
end

task automatic next_cycle;
    @(posedge clk_dac);
    #1;
endtask

task automatic next_tick;
    next_cycle();
    while (!m_tick) begin
        next_cycle();
    end
endtask

task automatic drive_random;
    logic [31:0] rnd;
    rnd = $random(seed);
    snd_left_i = rnd[SW-1:0];
    rnd = $random(seed);
    snd_right_i = rnd[SW-1:0];
endtask

// New samples every cycle; only those present at a tick are played
task automatic run_ticks(input int n, input bit quiet);
    int k;
    k = 0;
    while (k < n) begin
        drive_random();
        next_cycle();
        if (m_tick) begin
            k = k + 1;
        end
        if (quiet) begin
            check_val("dac_left_o quiet", 0, dac_left_o);
            check_val("dac_right_o quiet", 0, dac_right_o);
            check_val("playing_o quiet", 0, playing_o);
        end
        if (!stereo_i) begin
            check_val("dac_right_o mono copy", m_dac_l, dac_right_o);
        end
    end
endtask

task automatic warm_up;
    int n;
    int guard;
    n = 0;
    guard = 0;
    en_i = 1'b1;
    // First tick only leaves MUTE
    next_tick();
    check_val("playing_o at warm start", 0, playing_o);
    while (!playing_o && guard < 4 * WARM * DIV) begin
        next_cycle();
        guard = guard + 1;
        if (m_tick) begin
            n = n + 1;
        end
    end
    check_val("mid-scale warm-up ticks", WARM, n);
endtask

task automatic mute_pins;
    en_i = 1'b0;
    next_tick();
    check_val("playing_o after disable", 0, playing_o);
    next_cycle();
    check_val("dac_left_o after disable", 0, dac_left_o);
    check_val("dac_right_o after disable", 0, dac_right_o);
    run_ticks(MUTE_TICKS, 1'b1);
endtask

initial begin
    seed        = 32'h0e0cd206;
    clk_dac     = 1'b0;
    rst         = 1'b1;
    en_i        = 1'b0;
    signed_i    = 1'b1;
    stereo_i    = 1'b1;
    snd_left_i  = '0;
    snd_right_i = '0;
    test_name   = "reset";
    repeat (RST_CYC) @(posedge clk_dac);
    #1;
    rst = 1'b0;

    test_name = "idle_after_reset";
    run_ticks(IDLE_TICKS, 1'b1);

    test_name = "warm_up";
    warm_up();

    test_name = "signed_stereo";
    run_ticks(PLAY_TICKS, 1'b0);

    test_name = "mute";
    mute_pins();

    // Mode change while the pins are held at 0
    test_name = "restart_warm_up";
    signed_i = 1'b0;
    stereo_i = 1'b0;
    warm_up();

    test_name = "offset_mono";
    run_ticks(PLAY_TICKS, 1'b0);

    test_name = "final_mute";
    mute_pins();

    if (i_dut.i_props.fail_cnt != 0) begin
        $display("Error: %0d failures in the bound assertions", i_dut.i_props.fail_cnt);
        $display("TB FAILED");
        $fatal(1, "assertion failures");
    end else begin
        $display("TB PASSED");
        $finish;
    end
end

initial begin
    #(TIMEOUT_NS);
    $display("Error: watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
end

endmodule

`default_nettype wire

// File: all.f
+incdir+logic
logic/snd_pkg.sv
logic/snd_cen_timer.sv
logic/snd_ctrl_fsm.sv
logic/snd_sample_fmt.sv
logic/snd_sd_dac.sv
logic/snd_dac_top.sv
tests/snd_dac_props.sv
tests/tb_snd_dac.sv
